//--- logic/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// line size in bytes
`define ICACHE_LINE_BYTES 16

// direct mapped, one line per index
`define ICACHE_NUM_LINES 4

// address split, 32-bit address
`define ICACHE_OFFSET_BITS 4
`define ICACHE_INDEX_BITS 2
`define ICACHE_TAG_BITS 26

// refill is always one full line, one 32-bit word per beat
`define ICACHE_BURST_BEATS 4

`endif

//--- logic/fetch_pkg.sv
`include "icache_macros.svh"

package fetch_pkg;

    // lookup view of a fetch address
    // word selects the 32-bit slot inside the line
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]      tag;
        logic [`ICACHE_INDEX_BITS-1:0]    index;
        logic [`ICACHE_OFFSET_BITS-3:0]   word;
        logic [1:0]                       byte_sel;
    } fetch_addr_fields_t;

    // raw word for bus and response, fields for lookup
    typedef union packed {
        logic [31:0]        raw;
        fetch_addr_fields_t part;
    } fetch_addr_u;

    // fetch unit request, held until accepted
    typedef struct packed {
        logic        valid;
        fetch_addr_u addr;
    } fetch_req_t;

    // response back to the fetch unit
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } fetch_rsp_t;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

    // read address channel
    // araddr is always line aligned
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
    } bus_ar_t;

    // one read data beat
    // last flags the final beat of the burst
    typedef struct packed {
        logic        valid;
        logic        last;
        logic [31:0] data;
    } bus_r_t;

    // burst length is fixed, no arlen on the port
    // cache always takes data, no rready either

endpackage

//--- logic/icache_arrays.sv
`include "icache_macros.svh"

module icache_arrays
    import fetch_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  fetch_addr_u lookup_addr,
    input  logic        fill_we,
    input  logic [1:0]  fill_beat,
    input  logic [31:0] fill_data,
    input  logic        invalidate,
    output logic        hit,
    output logic [31:0] line_word
);

    localparam int LINE_BITS = `ICACHE_LINE_BYTES * 8;

    // storage, one entry per index
    logic [`ICACHE_TAG_BITS-1:0] tag_mem [`ICACHE_NUM_LINES];
    logic [LINE_BITS-1:0]        data_mem [`ICACHE_NUM_LINES];
    logic [`ICACHE_NUM_LINES-1:0] line_valid;

    // fields of the current lookup
    logic [`ICACHE_INDEX_BITS-1:0] index;
    logic [`ICACHE_TAG_BITS-1:0]   tag;
    logic [LINE_BITS-1:0]          sel_line;

    assign index = lookup_addr.part.index;
    assign tag = lookup_addr.part.tag;

    // line at the lookup index
    assign sel_line = data_mem[index];

    // tag compare only counts under the valid bit
    assign hit = line_valid[index] && (tag_mem[index] == tag);

    // addressed word out of the line
    assign line_word = sel_line[{lookup_addr.part.word, 5'b0} +: 32];

    // valid bits
    // fence clears every line, wins over a fill on the same edge
    always_ff @(posedge clock) begin
        if (reset || invalidate) begin
            line_valid <= '0;
        end else if (fill_we) begin
            // line counts as valid from the first beat
            // lookup holds off until the burst is done
            line_valid[index] <= 1'b1;
        end
    end

    // tag and data
    // fill index comes from the held lookup address
    always_ff @(posedge clock) begin
        if (fill_we) begin
            tag_mem[index] <= tag;
            // one beat into its word slot
            data_mem[index][{fill_beat, 5'b0} +: 32] <= fill_data;
        end
    end

    // burst beats land in order 0..3, so words below
    // the last beat are already in the line when
    // the refill completes

endmodule

//--- logic/icache_refill.sv
`include "icache_macros.svh"

module icache_refill
    import fetch_pkg::*;
    import bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        miss_start,
    input  fetch_addr_u lookup_addr,
    input  logic        arready,
    input  bus_r_t      bus_r,
    output bus_ar_t     bus_ar,
    output logic        refill_busy,
    output logic        fill_we,
    output logic [1:0]  fill_beat,
    output logic        fill_done
);

    localparam int BEAT_BITS = $clog2(`ICACHE_BURST_BEATS);

    // refill sequence
    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_read
    } refill_state_t;

    refill_state_t state;

    // line aligned burst address
    logic [31:0] araddr_q;

    // beat counter inside the burst
    logic [BEAT_BITS-1:0] beat_q;

    // address handshake
    logic ar_fire;

    assign ar_fire = (state == st_addr) && arready;

    // state register
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // lookup reports a clean miss
                    if (miss_start) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    // hold arvalid until the slave takes it
                    if (ar_fire) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    // back to idle on the last beat edge
                    if (bus_r.valid && bus_r.last) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // capture the line address at miss time
    // offset bits forced to zero
    always_ff @(posedge clock) begin
        if (miss_start) begin
            araddr_q <= {lookup_addr.raw[31:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}};
        end
    end

    // beat count, restarts on every miss
    always_ff @(posedge clock) begin
        if (reset || miss_start) begin
            beat_q <= '0;
        end else if (fill_we) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // arvalid is up exactly while waiting for the handshake
    assign bus_ar.arvalid = (state == st_addr);
    assign bus_ar.araddr = araddr_q;

    // every valid beat in the read phase goes into the line
    assign fill_we = (state == st_read) && bus_r.valid;
    assign fill_beat = beat_q;
    assign fill_done = fill_we && bus_r.last;

    assign refill_busy = (state != st_idle);

endmodule

//--- logic/icache_lookup.sv
module icache_lookup
    import fetch_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  fetch_req_t  fetch_req,
    input  logic        rsp_ready,
    input  logic        decode_stall,
    input  logic        mem_stall,
    input  logic        flush,
    input  logic        fence_i,
    input  logic        hit,
    input  logic [31:0] line_word,
    input  logic        refill_busy,
    input  logic        fill_done,
    input  logic [31:0] last_data,
    output fetch_addr_u lookup_addr,
    output logic        miss_start,
    output logic        invalidate,
    output logic        fetch_stall,
    output fetch_rsp_t  fetch_rsp
);

    // lookup register is empty, next request goes straight in
    logic first_req;

    // flush seen while a refill runs
    logic flush_r;

    // decision terms
    logic stall;
    logic go;
    logic entry_done;
    logic slot_free;
    logic accept;
    logic reg_rsp;
    logic drop_entry;

    // response register
    logic        rsp_valid;
    logic [31:0] rsp_addr;
    logic [31:0] rsp_data;

    assign stall = decode_stall || mem_stall;

    // pipeline may move this cycle
    assign go = !stall && rsp_ready && !flush && !fence_i;

    // held entry finishes: hit in idle, or a refill ending unflushed
    assign entry_done = (hit && !refill_busy) || (fill_done && !flush_r);

    // slot opens when empty and idle, or when the held entry finishes
    assign slot_free = first_req ? !refill_busy : entry_done;

    assign accept = go && slot_free;

    // a finishing entry registers its word on the same edge
    assign reg_rsp = accept && !first_req;

    // clean miss on a held entry
    assign miss_start = !first_req && !hit && !refill_busy && !stall && !flush && rsp_ready;

    // flush drops the entry at once in idle
    // during a refill it waits for the last beat
    assign drop_entry = (flush && !refill_busy) || (fill_done && (flush || flush_r));

    assign fetch_stall = !accept;
    assign invalidate = fence_i;

    // first request state
    always_ff @(posedge clock) begin
        if (reset || drop_entry) begin
            first_req <= 1'b1;
        end else if (accept) begin
            // slot stays empty when no request is offered
            first_req <= !fetch_req.valid;
        end
    end

    // lookup address, steady through a refill
    // arrays take the fill index from it
    always_ff @(posedge clock) begin
        if (accept && fetch_req.valid) begin
            lookup_addr <= fetch_req.addr;
        end
    end

    // delayed flush
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_r <= 1'b0;
        end else if (!refill_busy || fill_done) begin
            flush_r <= 1'b0;
        end else if (flush) begin
            flush_r <= 1'b1;
        end
    end

    // response valid
    // rsp_ready is part of go, so any older response
    // is consumed on the edge that registers a new one
    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (flush || fence_i) begin
            rsp_valid <= 1'b0;
        end else if (reg_rsp) begin
            rsp_valid <= 1'b1;
        end else if (fetch_rsp.valid && rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // response payload
    always_ff @(posedge clock) begin
        if (reg_rsp) begin
            rsp_addr <= lookup_addr.raw;
            // word three is still on the bus at completion
            if (fill_done && (lookup_addr.part.word == 2'd3)) begin
                rsp_data <= last_data;
            end else begin
                rsp_data <= line_word;
            end
        end
    end

    // nothing leaves in the flush cycle
    assign fetch_rsp.valid = rsp_valid && !flush;
    assign fetch_rsp.addr = rsp_addr;
    assign fetch_rsp.data = rsp_data;

endmodule

//--- logic/icache_top.sv
module icache_top
    import fetch_pkg::*;
    import bus_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  fetch_req_t fetch_req,
    input  logic       rsp_ready,
    input  logic       decode_stall,
    input  logic       mem_stall,
    input  logic       flush,
    input  logic       fence_i,
    output logic       fetch_stall,
    output fetch_rsp_t fetch_rsp,
    output bus_ar_t    bus_ar,
    input  logic       arready,
    input  bus_r_t     bus_r
);

    // lookup to arrays and refill
    fetch_addr_u lookup_addr;
    logic        miss_start;
    logic        invalidate;

    // arrays back to lookup
    logic        hit;
    logic [31:0] line_word;

    // refill control
    logic        refill_busy;
    logic        fill_we;
    logic [1:0]  fill_beat;
    logic        fill_done;

    icache_lookup u_lookup (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .rsp_ready    (rsp_ready),
        .decode_stall (decode_stall),
        .mem_stall    (mem_stall),
        .flush        (flush),
        .fence_i      (fence_i),
        .hit          (hit),
        .line_word    (line_word),
        .refill_busy  (refill_busy),
        .fill_done    (fill_done),
        // last beat data, forwarded for word three
        .last_data    (bus_r.data),
        .lookup_addr  (lookup_addr),
        .miss_start   (miss_start),
        .invalidate   (invalidate),
        .fetch_stall  (fetch_stall),
        .fetch_rsp    (fetch_rsp)
    );

    icache_arrays u_arrays (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .fill_we     (fill_we),
        .fill_beat   (fill_beat),
        .fill_data   (bus_r.data),
        .invalidate  (invalidate),
        .hit         (hit),
        .line_word   (line_word)
    );

    icache_refill u_refill (
        .clock       (clock),
        .reset       (reset),
        .miss_start  (miss_start),
        .lookup_addr (lookup_addr),
        .arready     (arready),
        .bus_r       (bus_r),
        .bus_ar      (bus_ar),
        .refill_busy (refill_busy),
        .fill_we     (fill_we),
        .fill_beat   (fill_beat),
        .fill_done   (fill_done)
    );

endmodule

//--- tests/axi_burst_mem.sv
`include "icache_macros.svh"

module axi_burst_mem
    import bus_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  bus_ar_t bus_ar,
    output logic    arready,
    output bus_r_t  bus_r
);

    timeunit 1ns;
    timeprecision 1ps;

    // delay stream for arready and beat gaps
    int seed = 32'h469844fd;

    // memory content rule
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    // outputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // random wait of 0..max_gap cycles
    task automatic idle_cycles(input int max_gap);
        int gap;
        gap = $unsigned($random(seed)) % (max_gap + 1);
        repeat (gap) next_cycle();
    endtask

    initial begin
        logic [31:0] line_addr;
        arready = 1'b0;
        bus_r = '0;
        forever begin
            next_cycle();
            if (!reset && bus_ar.arvalid) begin
                line_addr = bus_ar.araddr;
                // address accept after a random delay
                idle_cycles(3);
                arready = 1'b1;
                next_cycle();
                arready = 1'b0;
                // beats in order, gaps between them
                for (int beat = 0; beat < `ICACHE_BURST_BEATS; beat++) begin
                    idle_cycles(2);
                    bus_r.valid = 1'b1;
                    bus_r.last = (beat == `ICACHE_BURST_BEATS - 1);
                    bus_r.data = word_at(line_addr + 4 * beat);
                    next_cycle();
                    bus_r = '0;
                end
            end
        end
    end

endmodule

//--- tests/tb_icache.sv
module tb_icache
    import fetch_pkg::*;
    import bus_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT = 200;
    // watchdog sizing
    localparam int FETCH_COUNT = 40;
    localparam int WORST_MISS_CYCLES = 24;

    logic       clock;
    logic       reset;
    fetch_req_t fetch_req;
    logic       rsp_ready;
    logic       decode_stall;
    logic       mem_stall;
    logic       flush;
    logic       fence_i;
    logic       fetch_stall;
    fetch_rsp_t fetch_rsp;
    bus_ar_t    bus_ar;
    logic       arready;
    bus_r_t     bus_r;

    int stim_seed = 32'h469844fd;
    int noise_seed = 32'h469844fd;
    int errors = 0;
    int tests_run = 0;
    int failed_tests = 0;
    bit noise_on = 0;

    // accepted addresses in order popped by responses
    logic [31:0] exp_addr [64];
    logic [5:0]  wr_ptr;
    logic [5:0]  rd_ptr;
    int          cycle;
    int          acc_cycle;
    int          fire_cycle;
    int          ar_count;
    int          rsp_count;
    logic [31:0] last_araddr;
    logic [31:0] last_rsp_addr;

    icache_top uut (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .rsp_ready    (rsp_ready),
        .decode_stall (decode_stall),
        .mem_stall    (mem_stall),
        .flush        (flush),
        .fence_i      (fence_i),
        .fetch_stall  (fetch_stall),
        .fetch_rsp    (fetch_rsp),
        .bus_ar       (bus_ar),
        .arready      (arready),
        .bus_r        (bus_r)
    );

    axi_burst_mem mem (
        .clock   (clock),
        .reset   (reset),
        .bus_ar  (bus_ar),
        .arready (arready),
        .bus_r   (bus_r)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // word the memory holds at a fetch address
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    // accept, response and bus bookkeeping
    always_ff @(posedge clock) begin
        cycle <= cycle + 1;
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ar_count <= 0;
            rsp_count <= 0;
        end else begin
            if (fetch_req.valid && !fetch_stall) begin
                exp_addr[wr_ptr] <= fetch_req.addr.raw;
                wr_ptr <= wr_ptr + 1'b1;
                acc_cycle <= cycle;
            end
            // flush drops everything accepted and not yet returned
            if (flush) begin
                rd_ptr <= wr_ptr;
            end else if (fetch_rsp.valid && rsp_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
                fire_cycle <= cycle;
                rsp_count <= rsp_count + 1;
                last_rsp_addr <= fetch_rsp.addr;
            end
            if (bus_ar.arvalid && arready) begin
                ar_count <= ar_count + 1;
                last_araddr <= bus_ar.araddr;
            end
        end
    end

    a_rsp_expected: assert property (@(posedge clock) disable iff (reset)
        fetch_rsp.valid && rsp_ready |-> rd_ptr != wr_ptr)
        else begin
            errors++;
            $display("response returned with no accepted request waiting");
        end

    a_rsp_order: assert property (@(posedge clock) disable iff (reset)
        fetch_rsp.valid && rsp_ready && rd_ptr != wr_ptr |-> fetch_rsp.addr == exp_addr[rd_ptr])
        else begin
            errors++;
            $display("error fetch_rsp.addr: got %h expected %h",
                     $sampled(fetch_rsp.addr), $sampled(exp_addr[rd_ptr]));
        end

    a_rsp_data: assert property (@(posedge clock) disable iff (reset)
        fetch_rsp.valid |-> fetch_rsp.data == expected_word(fetch_rsp.addr))
        else begin
            errors++;
            $display("error fetch_rsp.data: got %h expected %h",
                     $sampled(fetch_rsp.data), expected_word($sampled(fetch_rsp.addr)));
        end

    a_no_rsp_on_flush: assert property (@(posedge clock) disable iff (reset)
        flush |-> !fetch_rsp.valid)
        else begin
            errors++;
            $display("response was valid in a flush cycle");
        end

    // held response keeps its payload
    a_rsp_hold: assert property (@(posedge clock) disable iff (reset)
        fetch_rsp.valid && !rsp_ready && !fence_i |=>
            (fetch_rsp.valid || flush) && $stable(fetch_rsp.addr) && $stable(fetch_rsp.data))
        else begin
            errors++;
            $display("error fetch_rsp: held response changed, addr %h data %h",
                     $sampled(fetch_rsp.addr), $sampled(fetch_rsp.data));
        end

    a_stall_blocks: assert property (@(posedge clock) disable iff (reset)
        decode_stall || mem_stall || !rsp_ready |-> fetch_stall)
        else begin
            errors++;
            $display("request could be taken while stalled or not ready");
        end

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        bus_ar.arvalid && !arready |=> bus_ar.arvalid && $stable(bus_ar.araddr))
        else begin
            errors++;
            $display("arvalid or araddr changed before the address handshake");
        end

    a_ar_drop: assert property (@(posedge clock) disable iff (reset)
        bus_ar.arvalid && arready |=> !bus_ar.arvalid)
        else begin
            errors++;
            $display("arvalid stayed high after the address handshake");
        end

    a_ar_aligned: assert property (@(posedge clock) disable iff (reset)
        bus_ar.arvalid |-> bus_ar.araddr[3:0] == 4'h0)
        else begin
            errors++;
            $display("error bus_ar.araddr: got %h, not line aligned", $sampled(bus_ar.araddr));
        end

    // random back-pressure while the stress test runs
    initial begin
        forever begin
            @(posedge clock);
            if (noise_on) begin
                #1;
                rsp_ready = ($unsigned($random(noise_seed)) % 4) != 0;
                decode_stall = ($unsigned($random(noise_seed)) % 8) == 0;
                mem_stall = ($unsigned($random(noise_seed)) % 8) == 0;
            end
        end
    end

    initial begin
        #((RESET_CYCLES + FETCH_COUNT * WORST_MISS_CYCLES * 4 + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic expect_equal(input string name, input int got, input int exp);
        assert (got == exp)
        else begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // hold the request until the cache takes it
    task automatic do_fetch(input logic [31:0] addr);
        int n;
        logic [5:0] ptr_before;
        fetch_req.valid = 1'b1;
        fetch_req.addr.raw = addr;
        ptr_before = wr_ptr;
        n = 0;
        while (wr_ptr == ptr_before && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        fetch_req.valid = 1'b0;
        if (wr_ptr == ptr_before) begin
            errors++;
            $display("fetch of %h was never accepted", addr);
        end
    endtask

    // all accepted fetches answered and no address pending
    task automatic wait_idle();
        int n;
        n = 0;
        while ((rd_ptr != wr_ptr || bus_ar.arvalid) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (rd_ptr != wr_ptr) begin
            errors++;
            $display("accepted fetches got no response in time");
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e;
        int ar_before;
        int rsp_before;
        int n;
        logic [31:0] bases [3];
        bases[0] = 32'h0000_1000;
        bases[1] = 32'h0000_4000;
        bases[2] = 32'h0000_3030;
        reset = 1'b1;
        fetch_req = '0;
        rsp_ready = 1'b1;
        decode_stall = 1'b0;
        mem_stall = 1'b0;
        flush = 1'b0;
        fence_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();

        // cold miss then a hit in the same line
        e = errors;
        ar_before = ar_count;
        do_fetch(32'h0000_1004);
        wait_idle();
        expect_equal("ar_count", ar_count, ar_before + 1);
        expect_equal("bus_ar.araddr", last_araddr, 32'h0000_1000);
        do_fetch(32'h0000_1008);
        wait_idle();
        expect_equal("ar_count", ar_count, ar_before + 1);
        expect_equal("hit latency", fire_cycle - acc_cycle, 2);
        finish_test("miss_then_hit", e);

        // word three forwarded from the last beat
        e = errors;
        ar_before = ar_count;
        do_fetch(32'h0000_303c);
        do_fetch(32'h0000_3030);
        do_fetch(32'h0000_3034);
        do_fetch(32'h0000_3038);
        wait_idle();
        expect_equal("ar_count", ar_count, ar_before + 1);
        finish_test("all_words", e);

        // same index with different tags
        e = errors;
        ar_before = ar_count;
        do_fetch(32'h0000_1020);
        do_fetch(32'h0000_2024);
        do_fetch(32'h0000_1028);
        wait_idle();
        expect_equal("ar_count", ar_count, ar_before + 3);
        finish_test("index_conflict", e);

        // fence drops a line that hit before
        e = errors;
        fence_i = 1'b1;
        next_cycle();
        fence_i = 1'b0;
        ar_before = ar_count;
        do_fetch(32'h0000_1028);
        wait_idle();
        expect_equal("ar_count", ar_count, ar_before + 1);
        finish_test("fence_i", e);

        // flush right after the address goes out
        e = errors;
        ar_before = ar_count;
        rsp_before = rsp_count;
        do_fetch(32'h0000_6004);
        n = 0;
        while (ar_count == ar_before && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        do_fetch(32'h0000_7018);
        wait_idle();
        // flush also drops a hit response the fetch unit holds off
        do_fetch(32'h0000_701c);
        next_cycle();
        rsp_ready = 1'b0;
        next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        rsp_ready = 1'b1;
        wait_idle();
        expect_equal("rsp_count", rsp_count, rsp_before + 1);
        expect_equal("fetch_rsp.addr", last_rsp_addr, 32'h0000_7018);
        finish_test("flush", e);

        // mixed hits and misses under random back-pressure
        e = errors;
        noise_on = 1;
        for (int i = 0; i < 24; i++) begin
            do_fetch(bases[$unsigned($random(stim_seed)) % 3] +
                     4 * ($unsigned($random(stim_seed)) % 4));
        end
        noise_on = 0;
        next_cycle();
        rsp_ready = 1'b1;
        decode_stall = 1'b0;
        mem_stall = 1'b0;
        wait_idle();
        finish_test("backpressure", e);

        $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- icache_fetch.f
+incdir+logic
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/icache_arrays.sv
logic/icache_refill.sv
logic/icache_lookup.sv
logic/icache_top.sv
tests/axi_burst_mem.sv
tests/tb_icache.sv

//--- Makefile
# Verilator build and run of the icache_fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
